//--- Makefile
# Verilator build and run for the IP packet CRC-32 checker

VERILATOR ?= verilator
TOP       ?= tb_ippcrc
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- logic/ippcrc_apb_regs.sv
/*
 * APB register block of the CRC checker
 * Zero-wait-state slave with the control register, saturating good and
 * bad packet counters and the CRC of the last packet
 */

module ippcrc_apb_regs
    import ippcrc_pkg::*;
#(
    parameter int CNT_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  crc_result_t           result,
    output logic                  enable
);

    localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;

    logic                 access;
    logic                 addr_hit;
    logic                 ctrl_wr;
    logic                 cnt_clear;
    logic [CNT_WIDTH-1:0] good_cnt;
    logic [CNT_WIDTH-1:0] bad_cnt;
    logic [31:0]          last_crc;

    // Clear wins over a coinciding increment
    function automatic logic [CNT_WIDTH-1:0] count_next(input logic [CNT_WIDTH-1:0] cnt,
                                                        input logic hit,
                                                        input logic clr);
        if (clr) begin
            return '0;
        end
        if (hit && cnt != CNT_MAX) begin
            return cnt + CNT_WIDTH'(1);
        end
        return cnt;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode

    assign access    = psel && penable;
    assign addr_hit  = paddr inside {REG_CTRL, REG_GOOD_CNT, REG_BAD_CNT, REG_LAST_CRC};
    assign ctrl_wr   = access && pwrite && (paddr == REG_CTRL);
    assign cnt_clear = ctrl_wr && pwdata[CTRL_CLEAR_BIT];

    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL:     prdata[CTRL_ENABLE_BIT] = enable;
            REG_GOOD_CNT: prdata = 32'(good_cnt);
            REG_BAD_CNT:  prdata = 32'(bad_cnt);
            REG_LAST_CRC: prdata = last_crc;
            default:      prdata = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
        end else if (ctrl_wr) begin
            enable <= pwdata[CTRL_ENABLE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            good_cnt <= '0;
            bad_cnt  <= '0;
        end else begin
            good_cnt <= count_next(good_cnt, result.valid && result.good, cnt_clear);
            bad_cnt  <= count_next(bad_cnt, result.valid && !result.good, cnt_clear);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_crc <= '0;
        end else if (result.valid) begin
            last_crc <= result.crc;
        end
    end

    // Access phase only follows a setup phase on the same slave
    a_penable_with_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel)
        else $error("penable without psel");

endmodule

//--- logic/ippcrc_crc32_48b.sv
/*
 * CRC-32 parallel update over one full 48-bit beat
 * The first 32 data bits are folded into the state bit-reversed,
 * then each output bit is the parity of a fixed set of state and
 * tail data bits, equal to 48 steps of the bit-serial CRC
 */

module ippcrc_crc32_48b
    import ippcrc_pkg::*;
(
    input  logic [31:0] ci,
    input  logic [47:0] di,
    output logic [31:0] co
);

    // Masks indexed [output bit][input bit]
    typedef logic [31:0][31:0] state_mask_t;
    typedef logic [31:0][15:0] data_mask_t;

    ////////////////////////////////////////////////////////////////////////////
    // Equation generation

    // One bit-serial step
    function automatic logic [31:0] crc_step(input logic [31:0] s, input logic b);
        logic fb;
        fb = s[31] ^ b;
        return fb ? ((s << 1) ^ CRC_POLY) : (s << 1);
    endfunction

    // Contribution of each merged state bit after 48 steps with zero data
    function automatic state_mask_t build_state_mask();
        state_mask_t m;
        logic [31:0] s;
        m = '0;
        for (int j = 0; j < 32; j++) begin
            s = 32'd1 << j;
            for (int k = 0; k < 48; k++) begin
                s = crc_step(s, 1'b0);
            end
            for (int i = 0; i < 32; i++) begin
                m[i][j] = s[i];
            end
        end
        return m;
    endfunction

    // Contribution of data bits 32..47, fed in the last 16 steps
    function automatic data_mask_t build_data_mask();
        data_mask_t m;
        logic [31:0] s;
        m = '0;
        for (int j = 0; j < 16; j++) begin
            s = '0;
            for (int k = 0; k < 16; k++) begin
                s = crc_step(s, k == j);
            end
            for (int i = 0; i < 32; i++) begin
                m[i][j] = s[i];
            end
        end
        return m;
    endfunction

    localparam state_mask_t X_MASK = build_state_mask();
    localparam data_mask_t  D_MASK = build_data_mask();

    ////////////////////////////////////////////////////////////////////////////
    // Datapath

    logic [31:0] swdi;
    logic [31:0] dx;
    logic [15:0] dt;

    // di[0] lands on bit 31, where it meets the first feedback
    assign swdi = {<<{di[31:0]}};
    assign dx   = ci ^ swdi;
    assign dt   = di[47:32];

    for (genvar i = 0; i < 32; i++) begin : g_eq
        assign co[i] = (^(dx & X_MASK[i])) ^ (^(dt & D_MASK[i]));
    end

endmodule

//--- logic/ippcrc_crc32_tail.sv
/*
 * CRC-32 update over the first 1 to 6 bytes of a beat
 * Six cascaded byte stages, the output taken after nbytes of them
 */

module ippcrc_crc32_tail
    import ippcrc_pkg::*;
(
    input  logic [31:0] ci,
    input  logic [47:0] di,
    input  logic [2:0]  nbytes,
    output logic [31:0] co
);

    // Eight bit-serial steps, LSB of the byte first
    function automatic logic [31:0] crc_byte(input logic [31:0] s, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = s;
        for (int k = 0; k < 8; k++) begin
            fb = r[31] ^ b[k];
            r  = fb ? ((r << 1) ^ CRC_POLY) : (r << 1);
        end
        return r;
    endfunction

    // stage[n] is the state after n bytes
    logic [31:0] stage [0:6];

    assign stage[0] = ci;

    for (genvar g = 0; g < 6; g++) begin : g_byte
        assign stage[g+1] = crc_byte(stage[g], di[8*g +: 8]);
    end

    always_comb begin
        case (nbytes)
            3'd1:    co = stage[1];
            3'd2:    co = stage[2];
            3'd3:    co = stage[3];
            3'd4:    co = stage[4];
            3'd5:    co = stage[5];
            3'd6:    co = stage[6];
            // Out of range, caught by the engine assertion
            default: co = stage[6];
        endcase
    end

endmodule

//--- logic/ippcrc_engine.sv
/*
 * CRC-32 checking engine
 * Keeps the running CRC of the open packet, folding full beats through
 * the 48-bit update and the eop beat through the byte-wise tail update.
 * At eop the register is checked against the residue and a one-cycle
 * result is issued on the next cycle
 */

module ippcrc_engine
    import ippcrc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  crc_beat_t   beat,
    output crc_result_t result
);

    logic        accept;
    logic        in_pkt;
    logic [31:0] crc_q;
    logic [31:0] crc_start;
    logic [31:0] crc_full;
    logic [31:0] crc_tail;

    logic        res_valid;
    logic        res_good;
    logic [31:0] res_crc;

    ////////////////////////////////////////////////////////////////////////////
    // Beat acceptance and update selection

    // Beats outside a packet are dropped until the next sop
    assign accept    = enable && beat.valid && (beat.sop || in_pkt);
    assign crc_start = beat.sop ? CRC_INIT : crc_q;

    ippcrc_crc32_48b u_full (
        .ci (crc_start),
        .di (beat.data),
        .co (crc_full)
    );

    ippcrc_crc32_tail u_tail (
        .ci     (crc_start),
        .di     (beat.data),
        .nbytes (beat.nbytes),
        .co     (crc_tail)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
        end else if (accept) begin
            in_pkt <= !beat.eop;
        end
    end

    // Reloaded from CRC_INIT at every sop
    always_ff @(posedge clk) begin
        if (accept) begin
            crc_q <= beat.eop ? crc_tail : crc_full;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Verdict

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= accept && beat.eop;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && beat.eop) begin
            res_good <= (crc_tail == CRC_RESIDUE);
            res_crc  <= ~crc_tail;
        end
    end

    assign result = '{valid: res_valid, good: res_good, crc: res_crc};

    // Tail length must fit the byte cascade
    a_nbytes_range: assert property (@(posedge clk) disable iff (reset)
        (accept && beat.eop) |-> (beat.nbytes inside {[3'd1:3'd6]}))
        else $error("eop beat with nbytes %0d", beat.nbytes);

    // Every packet is closed by an eop before the next sop
    a_no_nested_sop: assert property (@(posedge clk) disable iff (reset)
        (enable && beat.valid && beat.sop) |-> !in_pkt)
        else $error("sop while a packet is still open");

endmodule

//--- logic/ippcrc_pkg.sv
/*
 * IP packet CRC-32 checker, shared definitions
 * Beat and result structs, CRC-32 constants and the APB register map
 * used by the engine, the register block and the top level
 */

package ippcrc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream and result types

    // One 6-byte beat, byte k in data[8k+7:8k], data[0] first on the wire
    typedef struct packed {
        logic        valid;
        logic        sop;
        logic        eop;
        logic [2:0]  nbytes;   // 1 to 6, only with eop
        logic [47:0] data;
    } crc_beat_t;

    // Verdict on one packet
    typedef struct packed {
        logic        valid;
        logic        good;
        logic [31:0] crc;      // complemented register at end of packet
    } crc_result_t;

    ////////////////////////////////////////////////////////////////////////////
    // CRC-32 constants

    localparam logic [31:0] CRC_POLY    = 32'h04C1_1DB7;
    localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
    // Register value after a frame with a correct FCS
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

    ////////////////////////////////////////////////////////////////////////////
    // APB register map

    localparam int APB_ADDR_W = 4;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 4'h0;
    localparam logic [APB_ADDR_W-1:0] REG_GOOD_CNT = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_BAD_CNT  = 4'h8;
    localparam logic [APB_ADDR_W-1:0] REG_LAST_CRC = 4'hC;

    // CTRL bits
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;   // write-1 pulse, reads 0

endpackage

//--- logic/ippcrc_top.sv
/*
 * IP packet CRC-32 checker, top level
 * Connects the checking engine to the APB register block
 */

module ippcrc_top
    import ippcrc_pkg::*;
#(
    parameter int CNT_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  crc_beat_t             beat,
    output crc_result_t           result,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // Enable from CTRL back to the engine
    logic enable;

    ippcrc_engine u_engine (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .beat   (beat),
        .result (result)
    );

    ippcrc_apb_regs #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .result  (result),
        .enable  (enable)
    );

endmodule

//--- sim.f
logic/ippcrc_pkg.sv
logic/ippcrc_crc32_48b.sv
logic/ippcrc_crc32_tail.sv
logic/ippcrc_engine.sv
logic/ippcrc_apb_regs.sv
logic/ippcrc_top.sv
sim/tb_ippcrc.sv

//--- sim/tb_ippcrc.sv
/*
 * Testbench for the IP packet CRC-32 checker
 * Sends random packets with bit-serial FCS, some corrupted, checks
 * each verdict against a reference model and reads the APB counters
 */

module tb_ippcrc
    import ippcrc_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_OFF         = 4;
    localparam int NUM_RAND_A      = 150;
    localparam int NUM_SHORT       = 6;
    localparam int NUM_RAND_B      = 100;
    localparam int TOTAL_PKTS      = NUM_OFF + NUM_RAND_A + NUM_SHORT + NUM_RAND_B;
    localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 200 + 1000;

    typedef struct packed {
        logic        good;
        logic [31:0] crc;
    } expect_t;

    logic                  clk;
    logic                  reset;
    crc_beat_t             beat;
    crc_result_t           result;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    // Set with each beat that the DUT should accept
    logic        beat_counts;
    logic        exp_valid_q = 1'b0;
    expect_t     exp_q [$];
    expect_t     exp_head;
    int          good_model;
    int          bad_model;
    logic [31:0] last_crc_model;
    logic [5:0]  tail_seen;
    logic [31:0] rd;

    ippcrc_top #(
        .CNT_WIDTH (16)
    ) DUT (
        .clk     (clk),
        .reset   (reset),
        .beat    (beat),
        .result  (result),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reference model

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Bit-serial CRC-32, LSB of each byte first on the wire
    function automatic logic [31:0] fold_byte(input logic [31:0] r, input logic [7:0] b);
        logic [31:0] s;
        logic        fb;
        s = r;
        for (int i = 0; i < 8; i++) begin
            fb = s[31] ^ b[i];
            s  = {s[30:0], 1'b0} ^ (fb ? CRC_POLY : 32'h0);
        end
        return s;
    endfunction

    // Result must follow each counted eop by exactly one cycle
    always @(posedge clk) begin
        exp_valid_q <= beat.valid && beat.eop && beat_counts;
    end

    always @(negedge clk) begin
        if (!reset) begin
            check_value("result.valid", 32'(result.valid), 32'(exp_valid_q));
            if (result.valid) begin
                exp_head = exp_q.pop_front();
                check_value("result.good", 32'(result.good), 32'(exp_head.good));
                check_value("result.crc", result.crc, exp_head.crc);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            beat        = '0;
            beat_counts = 1'b0;
        end
    endtask

    task automatic send_packet(input int payload_len, input bit corrupt, input bit counts);
        logic [7:0]  frame [$];
        logic [7:0]  fcs_byte;
        logic [31:0] r;
        int          nbeats;
        int          nlast;
        int          flip;
        crc_beat_t   b;
        frame.delete();
        r = CRC_INIT;
        for (int i = 0; i < payload_len; i++) begin
            frame.push_back(8'($urandom));
            r = fold_byte(r, frame[i]);
        end
        // FCS goes out bit 31 first
        for (int bi = 0; bi < 4; bi++) begin
            for (int i = 0; i < 8; i++) begin
                fcs_byte[i] = ~r[31 - 8 * bi - i];
            end
            frame.push_back(fcs_byte);
        end
        if (corrupt) begin
            flip = $urandom_range(frame.size() * 8 - 1);
            frame[flip / 8] = frame[flip / 8] ^ (8'd1 << (flip % 8));
        end
        r = CRC_INIT;
        foreach (frame[i]) begin
            r = fold_byte(r, frame[i]);
        end
        nbeats = (frame.size() + 5) / 6;
        nlast  = frame.size() - 6 * (nbeats - 1);
        if (counts) begin
            // A single flipped bit is always caught by CRC-32
            exp_q.push_back('{good: !corrupt, crc: ~r});
            if (!corrupt) begin
                good_model++;
            end else begin
                bad_model++;
            end
            last_crc_model       = ~r;
            tail_seen[nlast - 1] = 1'b1;
        end
        for (int k = 0; k < nbeats; k++) begin
            b.valid  = 1'b1;
            b.sop    = (k == 0);
            b.eop    = (k == nbeats - 1);
            b.nbytes = b.eop ? 3'(nlast) : 3'd6;
            for (int j = 0; j < 6; j++) begin
                // Bytes past the frame end carry noise
                b.data[8 * j +: 8] = (6 * k + j < frame.size()) ? frame[6 * k + j]
                                                                : 8'($urandom);
            end
            @(negedge clk);
            beat        = b;
            beat_counts = counts;
        end
    endtask

    task automatic run_random(input int n);
        for (int p = 0; p < n; p++) begin
            send_packet(4 + $urandom_range(60), $urandom_range(2) == 0, 1'b1);
            if ($urandom_range(1) == 0) begin
                idle_cycles($urandom_range(1, 4));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB access

    task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, input logic exp_err,
                              output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        check_value("pready", 32'(pready), 32'd1);
        check_value("pslverr", 32'(pslverr), 32'(exp_err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_check(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        apb_access(1'b0, addr, 32'h0, 1'b0, data);
        check_value(name, data, exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'h26a9));
        reset          = 1'b1;
        beat           = '0;
        beat_counts    = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        good_model     = 0;
        bad_model      = 0;
        last_crc_model = '0;
        tail_seen      = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        read_check(REG_CTRL, 32'h0, "CTRL");
        read_check(REG_GOOD_CNT, 32'h0, "GOOD_CNT");
        read_check(REG_BAD_CNT, 32'h0, "BAD_CNT");
        read_check(REG_LAST_CRC, 32'h0, "LAST_CRC");

        // Dropped while disabled
        for (int p = 0; p < NUM_OFF; p++) begin
            send_packet(4 + $urandom_range(60), 1'b0, 1'b0);
        end
        idle_cycles(3);

        apb_access(1'b1, REG_CTRL, 32'h1, 1'b0, rd);
        read_check(REG_CTRL, 32'h1, "CTRL");
        run_random(NUM_RAND_A);
        idle_cycles(3);
        check_value("pending results", 32'(exp_q.size()), 32'd0);
        read_check(REG_GOOD_CNT, 32'(good_model), "GOOD_CNT");
        read_check(REG_BAD_CNT, 32'(bad_model), "BAD_CNT");
        read_check(REG_LAST_CRC, last_crc_model, "LAST_CRC");

        // Counter clear keeps enable set
        apb_access(1'b1, REG_CTRL, 32'h3, 1'b0, rd);
        good_model = 0;
        bad_model  = 0;
        read_check(REG_CTRL, 32'h1, "CTRL");
        read_check(REG_GOOD_CNT, 32'h0, "GOOD_CNT");
        read_check(REG_BAD_CNT, 32'h0, "BAD_CNT");

        // One-beat packets, back to back
        for (int p = 0; p < NUM_SHORT; p++) begin
            send_packet(p % 3, $urandom_range(2) == 0, 1'b1);
        end
        run_random(NUM_RAND_B);
        idle_cycles(3);
        check_value("pending results", 32'(exp_q.size()), 32'd0);
        read_check(REG_GOOD_CNT, 32'(good_model), "GOOD_CNT");
        read_check(REG_BAD_CNT, 32'(bad_model), "BAD_CNT");
        read_check(REG_LAST_CRC, last_crc_model, "LAST_CRC");

        // Unmapped offsets
        apb_access(1'b0, 4'h2, 32'h0, 1'b1, rd);
        apb_access(1'b1, 4'h6, 32'h0, 1'b1, rd);
        check_value("tail lengths seen", 32'(tail_seen), 32'h3F);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
